/* hdl/core_settings.svh */
// Global width and reset settings for the multicycle RV32I core.
// Data path width, register index width and the reset PC.

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Width of data and addresses.
`define CORE_XLEN 32

// Width of a register index.
`define CORE_REG_ADDR_W 5

// First fetch address.
`define CORE_RESET_PC 32'h0000_0000

`endif

/* hdl/core_pkg.sv */
// Shared types for the multicycle core.
// Opcode and ALU-operation enums, mux selects, the control word,
// the ALU flags and the memory request.

`include "core_settings.svh"

package core_pkg;

    // Major opcodes of the supported instructions.
    typedef enum logic [6:0] {
        OP_OP     = 7'b0110011,
        OP_OP_IMM = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLTU   = 4'd6,
        ALU_PASS_B = 4'd7
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_PC, SRC1_OLD_PC, SRC1_REG_A} src1_sel_e;
    typedef enum logic [1:0] {SRC2_REG_B, SRC2_IMM, SRC2_FOUR} src2_sel_e;
    typedef enum logic [1:0] {RES_ALU_REG, RES_MEM_DATA, RES_ALU_LIVE} res_sel_e;
    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

    // Control word from the FSM to the datapath.
    typedef struct packed {
        alu_op_e   alu_op;
        src1_sel_e src1_sel;
        src2_sel_e src2_sel;
        res_sel_e  res_sel;
        imm_sel_e  imm_sel;
        logic      reg_we;
        logic      pc_we;
        logic      instr_we;
        logic      addr_we;
    } ctrl_t;

    // Comparison flags of src_1 minus src_2.
    typedef struct packed {
        logic zero;
        logic slt;
        logic sltu;
    } alu_flags_t;

    // Held stable for the whole access.
    typedef struct packed {
        logic [`CORE_XLEN-1:0] addr;
        logic [`CORE_XLEN-1:0] wdata;
    } mem_req_t;

endpackage

/* hdl/alu.sv */
// Combinational ALU.
// Result of the selected operation plus zero, signed-less and
// unsigned-less flags of src_1 minus src_2.

`timescale 1ns/100ps
`include "core_settings.svh"

module alu (
    input  core_pkg::alu_op_e     i_op,
    input  logic [`CORE_XLEN-1:0] i_src_1,
    input  logic [`CORE_XLEN-1:0] i_src_2,
    output logic [`CORE_XLEN-1:0] o_result,
    output core_pkg::alu_flags_t  o_flags
);

    // Extra top bit holds the borrow.
    logic [`CORE_XLEN:0] s_diff;

    assign s_diff = {1'b0, i_src_1} - {1'b0, i_src_2};

    assign o_flags.zero = (s_diff[`CORE_XLEN-1:0] == '0);
    assign o_flags.sltu = s_diff[`CORE_XLEN];
    assign o_flags.slt  = ($signed(i_src_1) < $signed(i_src_2));

    always_comb begin
        case (i_op)
            core_pkg::ALU_ADD:    o_result = i_src_1 + i_src_2;
            core_pkg::ALU_SUB:    o_result = s_diff[`CORE_XLEN-1:0];
            core_pkg::ALU_AND:    o_result = i_src_1 & i_src_2;
            core_pkg::ALU_OR:     o_result = i_src_1 | i_src_2;
            core_pkg::ALU_XOR:    o_result = i_src_1 ^ i_src_2;
            core_pkg::ALU_SLT:    o_result = `CORE_XLEN'(o_flags.slt);
            core_pkg::ALU_SLTU:   o_result = `CORE_XLEN'(o_flags.sltu);
            core_pkg::ALU_PASS_B: o_result = i_src_2;
            default:              o_result = '0;
        endcase
    end

endmodule

/* hdl/extend_imm.sv */
// Immediate extender.
// Builds the I, S, B, U and J immediates and sign-extends them.

`timescale 1ns/100ps
`include "core_settings.svh"

module extend_imm (
    input  core_pkg::imm_sel_e    i_sel,
    input  logic [31:0]           i_instr,
    output logic [`CORE_XLEN-1:0] o_imm
);

    logic [31:0] s_imm;

    always_comb begin
        case (i_sel)
            core_pkg::IMM_S: s_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            core_pkg::IMM_B: s_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                                      i_instr[30:25], i_instr[11:8], 1'b0};
            core_pkg::IMM_U: s_imm = {i_instr[31:12], 12'b0};
            core_pkg::IMM_J: s_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                                      i_instr[20], i_instr[30:21], 1'b0};
            default:         s_imm = {{20{i_instr[31]}}, i_instr[31:20]};
        endcase
    end

    // Sign extension to the data path width.
    assign o_imm = `CORE_XLEN'($signed(s_imm));

endmodule

/* hdl/register_file.sv */
// Architectural register file.
// Two combinational read ports, one write port, x0 hard-wired to zero.

`timescale 1ns/100ps
`include "core_settings.svh"

module register_file (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_we,
    input  logic [`CORE_REG_ADDR_W-1:0] i_addr_1,
    input  logic [`CORE_REG_ADDR_W-1:0] i_addr_2,
    input  logic [`CORE_REG_ADDR_W-1:0] i_addr_3,
    input  logic [`CORE_XLEN-1:0]       i_write_data,
    output logic [`CORE_XLEN-1:0]       o_read_data_1,
    output logic [`CORE_XLEN-1:0]       o_read_data_2
);

    logic [`CORE_XLEN-1:0] s_regs [2**`CORE_REG_ADDR_W];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**`CORE_REG_ADDR_W; i++) begin
                s_regs[i] <= '0;
            end
        end else if (i_we && (i_addr_3 != '0)) begin
            s_regs[i_addr_3] <= i_write_data;
        end
    end

    // Reads of x0 return zero.
    assign o_read_data_1 = (i_addr_1 == '0) ? '0 : s_regs[i_addr_1];
    assign o_read_data_2 = (i_addr_2 == '0) ? '0 : s_regs[i_addr_2];

endmodule

/* hdl/datapath_regs.sv */
// Non-architectural registers of the multicycle datapath.
// Instruction, PC, old PC, operands, ALU result, address and memory data,
// with the ALU source and result multiplexers.

`timescale 1ns/100ps
`include "core_settings.svh"

module datapath_regs (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  core_pkg::ctrl_t       i_ctrl,
    input  logic [`CORE_XLEN-1:0] i_read_data,
    input  logic [`CORE_XLEN-1:0] i_rf_data_a,
    input  logic [`CORE_XLEN-1:0] i_rf_data_b,
    input  logic [`CORE_XLEN-1:0] i_imm,
    input  logic [`CORE_XLEN-1:0] i_alu_result,
    output logic [31:0]           o_instr,
    output logic [`CORE_XLEN-1:0] o_src1,
    output logic [`CORE_XLEN-1:0] o_src2,
    output logic [`CORE_XLEN-1:0] o_result,
    output core_pkg::mem_req_t    o_req
);

    logic [`CORE_XLEN-1:0] s_pc;
    logic [`CORE_XLEN-1:0] s_old_pc;
    logic [`CORE_XLEN-1:0] s_addr;
    logic [`CORE_XLEN-1:0] s_opnd_a;
    logic [`CORE_XLEN-1:0] s_opnd_b;
    logic [`CORE_XLEN-1:0] s_alu_q;
    logic [`CORE_XLEN-1:0] s_mem_data;

    // ------------------------------
    // Enabled registers.
    // ------------------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_instr <= '0;
            s_pc    <= `CORE_RESET_PC;
            s_addr  <= `CORE_RESET_PC;
        end else begin
            if (i_ctrl.instr_we) begin
                o_instr <= i_read_data[31:0];
            end
            if (i_ctrl.pc_we) begin
                s_pc <= o_result;
            end
            if (i_ctrl.addr_we) begin
                s_addr <= o_result;
            end
        end
    end

    // Payload registers that mostly load every cycle.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s_old_pc   <= `CORE_RESET_PC;
            s_opnd_a   <= '0;
            s_opnd_b   <= '0;
            s_alu_q    <= '0;
            s_mem_data <= '0;
        end else begin
            if (i_ctrl.instr_we) begin
                s_old_pc <= s_pc;
            end
            s_opnd_a   <= i_rf_data_a;
            s_opnd_b   <= i_rf_data_b;
            s_alu_q    <= i_alu_result;
            s_mem_data <= i_read_data;
        end
    end

    // ------------------------------
    // Multiplexers.
    // ------------------------------
    always_comb begin
        case (i_ctrl.src1_sel)
            core_pkg::SRC1_OLD_PC: o_src1 = s_old_pc;
            core_pkg::SRC1_REG_A:  o_src1 = s_opnd_a;
            default:               o_src1 = s_pc;
        endcase
    end

    always_comb begin
        case (i_ctrl.src2_sel)
            core_pkg::SRC2_IMM:  o_src2 = i_imm;
            core_pkg::SRC2_FOUR: o_src2 = `CORE_XLEN'(4);
            default:             o_src2 = s_opnd_b;
        endcase
    end

    // Result bus feeds PC, register file and address register.
    always_comb begin
        case (i_ctrl.res_sel)
            core_pkg::RES_MEM_DATA: o_result = s_mem_data;
            core_pkg::RES_ALU_LIVE: o_result = i_alu_result;
            default:                o_result = s_alu_q;
        endcase
    end

    assign o_req.addr  = s_addr;
    assign o_req.wdata = s_opnd_b;

    // Instruction load only together with the fetch-completion PC update.
    a_instr_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_ctrl.instr_we |-> (i_ctrl.pc_we && i_ctrl.addr_we &&
                             i_ctrl.src1_sel == core_pkg::SRC1_PC &&
                             i_ctrl.res_sel == core_pkg::RES_ALU_LIVE))
        else $error("Instruction register written outside FETCH_WAIT.");

endmodule

/* hdl/control_unit.sv */
// Multicycle control FSM.
// Decodes opcode, funct3 and funct7[5] into the control word and
// sequences the fetch and data memory strobes.

`timescale 1ns/100ps

module control_unit (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic [31:0]          i_instr,
    input  core_pkg::alu_flags_t i_flags,
    input  logic                 i_read_last,
    input  logic                 i_b_resp,
    output core_pkg::ctrl_t      o_ctrl,
    output logic                 o_start_read,
    output logic                 o_start_write,
    output logic                 o_access
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_FETCH_WAIT,
        S_DECODE,
        S_EXECUTE,
        S_MEM,
        S_MEM_WAIT,
        S_WRITEBACK
    } state_e;

    state_e              s_state;
    state_e              s_state_next;
    core_pkg::opcode_e   s_opcode;
    logic [2:0]          s_funct3;
    logic                s_funct7_5;
    logic                s_is_load;
    logic                s_mem_done;
    logic                s_taken;
    core_pkg::alu_op_e   s_arith_op;
    core_pkg::imm_sel_e  s_imm_sel;

    assign s_opcode   = core_pkg::opcode_e'(i_instr[6:0]);
    assign s_funct3   = i_instr[14:12];
    assign s_funct7_5 = i_instr[30];
    assign s_is_load  = (s_opcode == core_pkg::OP_LOAD);
    assign s_mem_done = s_is_load ? i_read_last : i_b_resp;

    // ------------------------------
    // Field decode.
    // ------------------------------
    always_comb begin
        case (s_funct3)
            3'b000:  s_arith_op = (s_opcode == core_pkg::OP_OP && s_funct7_5) ?
                                  core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b010:  s_arith_op = core_pkg::ALU_SLT;
            3'b011:  s_arith_op = core_pkg::ALU_SLTU;
            3'b100:  s_arith_op = core_pkg::ALU_XOR;
            3'b110:  s_arith_op = core_pkg::ALU_OR;
            3'b111:  s_arith_op = core_pkg::ALU_AND;
            default: s_arith_op = core_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        case (s_opcode)
            core_pkg::OP_STORE:  s_imm_sel = core_pkg::IMM_S;
            core_pkg::OP_BRANCH: s_imm_sel = core_pkg::IMM_B;
            core_pkg::OP_LUI:    s_imm_sel = core_pkg::IMM_U;
            core_pkg::OP_JAL:    s_imm_sel = core_pkg::IMM_J;
            default:             s_imm_sel = core_pkg::IMM_I;
        endcase
    end

    // Branch condition from the flags of rs1 minus rs2.
    always_comb begin
        case (s_funct3)
            3'b000:  s_taken = i_flags.zero;
            3'b001:  s_taken = !i_flags.zero;
            3'b100:  s_taken = i_flags.slt;
            3'b101:  s_taken = !i_flags.slt;
            3'b110:  s_taken = i_flags.sltu;
            3'b111:  s_taken = !i_flags.sltu;
            default: s_taken = 1'b0;
        endcase
    end

    // ------------------------------
    // State register.
    // ------------------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s_state <= S_IDLE;
        end else begin
            s_state <= s_state_next;
        end
    end

    // ------------------------------
    // Next state and control word.
    // ------------------------------
    always_comb begin
        s_state_next     = s_state;
        o_ctrl.alu_op    = core_pkg::ALU_ADD;
        o_ctrl.src1_sel  = core_pkg::SRC1_PC;
        o_ctrl.src2_sel  = core_pkg::SRC2_FOUR;
        o_ctrl.res_sel   = core_pkg::RES_ALU_REG;
        o_ctrl.imm_sel   = s_imm_sel;
        o_ctrl.reg_we    = 1'b0;
        o_ctrl.pc_we     = 1'b0;
        o_ctrl.instr_we  = 1'b0;
        o_ctrl.addr_we   = 1'b0;

        case (s_state)
            S_IDLE:  s_state_next = S_FETCH;
            S_FETCH: s_state_next = S_FETCH_WAIT;
            S_FETCH_WAIT: begin
                // PC plus four goes to both PC and the address register.
                o_ctrl.res_sel = core_pkg::RES_ALU_LIVE;
                if (i_read_last) begin
                    o_ctrl.instr_we = 1'b1;
                    o_ctrl.pc_we    = 1'b1;
                    o_ctrl.addr_we  = 1'b1;
                    s_state_next    = S_DECODE;
                end
            end
            S_DECODE: begin
                // Branch or jump target from the old PC.
                o_ctrl.src1_sel = core_pkg::SRC1_OLD_PC;
                o_ctrl.src2_sel = core_pkg::SRC2_IMM;
                s_state_next    = S_EXECUTE;
            end
            S_EXECUTE: begin
                s_state_next    = S_FETCH;
                o_ctrl.src1_sel = core_pkg::SRC1_REG_A;
                o_ctrl.src2_sel = core_pkg::SRC2_IMM;
                case (s_opcode)
                    core_pkg::OP_OP: begin
                        o_ctrl.alu_op   = s_arith_op;
                        o_ctrl.src2_sel = core_pkg::SRC2_REG_B;
                        s_state_next    = S_WRITEBACK;
                    end
                    core_pkg::OP_OP_IMM: begin
                        o_ctrl.alu_op = s_arith_op;
                        s_state_next  = S_WRITEBACK;
                    end
                    core_pkg::OP_LUI: begin
                        o_ctrl.alu_op = core_pkg::ALU_PASS_B;
                        s_state_next  = S_WRITEBACK;
                    end
                    core_pkg::OP_LOAD, core_pkg::OP_STORE: begin
                        o_ctrl.res_sel = core_pkg::RES_ALU_LIVE;
                        o_ctrl.addr_we = 1'b1;
                        s_state_next   = S_MEM;
                    end
                    core_pkg::OP_BRANCH: begin
                        o_ctrl.alu_op   = core_pkg::ALU_SUB;
                        o_ctrl.src2_sel = core_pkg::SRC2_REG_B;
                        o_ctrl.pc_we    = s_taken;
                        o_ctrl.addr_we  = s_taken;
                    end
                    core_pkg::OP_JAL: begin
                        // Link value registered here while the target comes from DECODE.
                        o_ctrl.src1_sel = core_pkg::SRC1_OLD_PC;
                        o_ctrl.src2_sel = core_pkg::SRC2_FOUR;
                        o_ctrl.pc_we    = 1'b1;
                        o_ctrl.addr_we  = 1'b1;
                        s_state_next    = S_WRITEBACK;
                    end
                    default: s_state_next = S_FETCH;
                endcase
            end
            S_MEM: s_state_next = S_MEM_WAIT;
            S_MEM_WAIT: begin
                // Restore the fetch address to old PC plus four.
                o_ctrl.src1_sel = core_pkg::SRC1_OLD_PC;
                o_ctrl.res_sel  = core_pkg::RES_ALU_LIVE;
                if (s_mem_done) begin
                    o_ctrl.addr_we = 1'b1;
                    s_state_next   = s_is_load ? S_WRITEBACK : S_FETCH;
                end
            end
            S_WRITEBACK: begin
                o_ctrl.reg_we  = 1'b1;
                o_ctrl.res_sel = s_is_load ? core_pkg::RES_MEM_DATA : core_pkg::RES_ALU_REG;
                s_state_next   = S_FETCH;
            end
            default: s_state_next = S_IDLE;
        endcase
    end

    // ------------------------------
    // Memory port strobes.
    // ------------------------------
    assign o_start_read  = (s_state == S_FETCH) || (s_state == S_MEM && s_is_load);
    assign o_start_write = (s_state == S_MEM) && !s_is_load;
    assign o_access      = (s_state == S_FETCH) || (s_state == S_FETCH_WAIT) ||
                           (s_state == S_MEM)   || (s_state == S_MEM_WAIT);

    // A new access starts only once the previous one has completed.
    a_one_outstanding: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_start_read || o_start_write) |->
            (!$past(o_access) || $past(i_read_last || i_b_resp)))
        else $error("Strobe raised while an access was still outstanding.");

    // Access ends only after its completion pulse.
    a_access_end: assert property (@(posedge clk) disable iff (!i_rst_n)
        $fell(o_access) |-> $past(i_read_last || i_b_resp))
        else $error("Access dropped without a completion pulse.");

endmodule

/* hdl/core_top.sv */
// Top level of the multicycle RV32I core.
// Connects the control FSM, the datapath registers, the register file,
// the ALU and the immediate extender.

`timescale 1ns/100ps
`include "core_settings.svh"

module core_top (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_read_last,
    input  logic [`CORE_XLEN-1:0] i_read_data,
    input  logic                  i_b_resp,
    output logic                  o_start_read,
    output logic                  o_start_write,
    output logic                  o_access,
    output core_pkg::mem_req_t    o_req
);

    // ------------------------------
    // Internal nets.
    // ------------------------------
    core_pkg::ctrl_t       s_ctrl;
    core_pkg::alu_flags_t  s_flags;
    logic [31:0]           s_instr;
    logic [`CORE_XLEN-1:0] s_rf_data_a;
    logic [`CORE_XLEN-1:0] s_rf_data_b;
    logic [`CORE_XLEN-1:0] s_imm;
    logic [`CORE_XLEN-1:0] s_src1;
    logic [`CORE_XLEN-1:0] s_src2;
    logic [`CORE_XLEN-1:0] s_alu_result;
    logic [`CORE_XLEN-1:0] s_result;

    // ------------------------------
    // Control.
    // ------------------------------
    control_unit CU (
        .clk           ( clk           ),
        .i_rst_n       ( i_rst_n       ),
        .i_instr       ( s_instr       ),
        .i_flags       ( s_flags       ),
        .i_read_last   ( i_read_last   ),
        .i_b_resp      ( i_b_resp      ),
        .o_ctrl        ( s_ctrl        ),
        .o_start_read  ( o_start_read  ),
        .o_start_write ( o_start_write ),
        .o_access      ( o_access      )
    );

    // ------------------------------
    // Datapath.
    // ------------------------------
    datapath_regs DP_REGS (
        .clk          ( clk          ),
        .i_rst_n      ( i_rst_n      ),
        .i_ctrl       ( s_ctrl       ),
        .i_read_data  ( i_read_data  ),
        .i_rf_data_a  ( s_rf_data_a  ),
        .i_rf_data_b  ( s_rf_data_b  ),
        .i_imm        ( s_imm        ),
        .i_alu_result ( s_alu_result ),
        .o_instr      ( s_instr      ),
        .o_src1       ( s_src1       ),
        .o_src2       ( s_src2       ),
        .o_result     ( s_result     ),
        .o_req        ( o_req        )
    );

    // Read ports from rs1 and rs2, write port to rd.
    register_file REG_FILE (
        .clk           ( clk             ),
        .i_rst_n       ( i_rst_n         ),
        .i_we          ( s_ctrl.reg_we   ),
        .i_addr_1      ( s_instr[19:15]  ),
        .i_addr_2      ( s_instr[24:20]  ),
        .i_addr_3      ( s_instr[11:7]   ),
        .i_write_data  ( s_result        ),
        .o_read_data_1 ( s_rf_data_a     ),
        .o_read_data_2 ( s_rf_data_b     )
    );

    alu ALU (
        .i_op     ( s_ctrl.alu_op ),
        .i_src_1  ( s_src1        ),
        .i_src_2  ( s_src2        ),
        .o_result ( s_alu_result  ),
        .o_flags  ( s_flags       )
    );

    extend_imm I_EXT (
        .i_sel   ( s_ctrl.imm_sel ),
        .i_instr ( s_instr        ),
        .o_imm   ( s_imm          )
    );

endmodule

/* verif/mem_model.sv */
// Word memory model for the core testbench.
// Preloaded from a program image during reset, completes each access
// after a random delay and presents every write it accepts.

`timescale 1ns/100ps

module mem_model #(
    parameter int IMAGE_WORDS = 1
) (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_start_read,
    input  logic               i_start_write,
    input  core_pkg::mem_req_t i_req,
    input  logic [31:0]        i_image [IMAGE_WORDS],
    output logic               o_read_last,
    output logic [31:0]        o_read_data,
    output logic               o_b_resp,
    output core_pkg::mem_req_t o_wr
);

    localparam int DEPTH = 256;

    logic [31:0]        s_mem [DEPTH];
    core_pkg::mem_req_t s_req;
    logic               s_is_write;
    int                 s_delay;
    integer             s_seed;

    initial begin
        s_seed      = 32'h97019014;
        o_read_last = 1'b0;
        o_read_data = '0;
        o_b_resp    = 1'b0;
        o_wr        = '0;
    end

    always @(posedge clk) begin
        if (!i_rst_n) begin
            // Program image first, an address-based pattern above it.
            for (int i = 0; i < DEPTH; i++) begin
                s_mem[i] = (i < IMAGE_WORDS) ? i_image[i] : (32'hC0DE_0000 ^ 32'(i * 4));
            end
        end else if (i_start_read || i_start_write) begin
            s_req      = i_req;
            s_is_write = i_start_write;
            // One to four cycles until the completion pulse.
            s_delay    = 1 + ($unsigned($random(s_seed)) % 4);
            repeat (s_delay - 1) @(posedge clk);
            #1;
            if (s_is_write) begin
                s_mem[s_req.addr[9:2]] = s_req.wdata;
                o_wr                   = s_req;
                o_b_resp               = 1'b1;
            end else begin
                o_read_data = s_mem[s_req.addr[9:2]];
                o_read_last = 1'b1;
            end
            @(posedge clk);
            #1;
            o_read_last = 1'b0;
            o_b_resp    = 1'b0;
        end
    end

endmodule

/* verif/tb_core.sv */
// Testbench for the multicycle RV32I core.
// Clock and reset, program and expected-write tables, the write
// collector, the value check and the cycle limit.

`timescale 1ns/100ps
`include "core_settings.svh"

module tb_core;

    localparam int PROG_WORDS     = 38;
    localparam int N_WRITES       = 13;
    localparam int IDLE_CYCLES    = 20;
    // Worst case per instruction is 6 cycles plus two latencies of 4.
    localparam int TIMEOUT_CYCLES = PROG_WORDS * (6 + 2 * 4) * 2;

    localparam logic [6:0] OPC_IMM  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;

    logic                  clk;
    logic                  i_rst_n;
    logic                  s_read_last;
    logic [`CORE_XLEN-1:0] s_read_data;
    logic                  s_b_resp;
    logic                  s_start_read;
    logic                  s_start_write;
    logic                  s_access;
    core_pkg::mem_req_t    s_req;
    core_pkg::mem_req_t    s_wr;

    logic [31:0]        s_program [PROG_WORDS];
    core_pkg::mem_req_t exp_writes [N_WRITES];
    core_pkg::mem_req_t seen_q [$];
    int                 cycle_count = 0;

    core_top DUT (
        .clk           ( clk           ),
        .i_rst_n       ( i_rst_n       ),
        .i_read_last   ( s_read_last   ),
        .i_read_data   ( s_read_data   ),
        .i_b_resp      ( s_b_resp      ),
        .o_start_read  ( s_start_read  ),
        .o_start_write ( s_start_write ),
        .o_access      ( s_access      ),
        .o_req         ( s_req         )
    );

    mem_model #(.IMAGE_WORDS(PROG_WORDS)) MEM (
        .clk           ( clk           ),
        .i_rst_n       ( i_rst_n       ),
        .i_start_read  ( s_start_read  ),
        .i_start_write ( s_start_write ),
        .i_req         ( s_req         ),
        .i_image       ( s_program     ),
        .o_read_last   ( s_read_last   ),
        .o_read_data   ( s_read_data   ),
        .o_b_resp      ( s_b_resp      ),
        .o_wr          ( s_wr          )
    );

    // ------------------------------
    // Instruction encoders.
    // ------------------------------
    function automatic logic [31:0] rtype(input logic [6:0] funct7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3,
                                          input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] funct3, input logic [4:0] rd,
                                          input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    // Stores are always word stores here.
    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // ------------------------------
    // Program and expected writes.
    // ------------------------------
    task automatic assemble_program();
        s_program[0]  = itype(12'd25, 5'd0, 3'b000, 5'd1, OPC_IMM);     // x1 = 25.
        s_program[1]  = itype(12'hFF9, 5'd0, 3'b000, 5'd2, OPC_IMM);    // x2 = -7.
        s_program[2]  = itype(12'h200, 5'd0, 3'b000, 5'd10, OPC_IMM);   // Data base.
        s_program[3]  = utype(20'h12345, 5'd3);
        s_program[4]  = itype(12'h678, 5'd3, 3'b000, 5'd7, OPC_IMM);
        s_program[5]  = itype(12'hF00, 5'd0, 3'b000, 5'd8, OPC_IMM);    // x8 = -256.
        s_program[6]  = stype(12'd0, 5'd1, 5'd10);
        s_program[7]  = stype(12'd4, 5'd3, 5'd10);
        s_program[8]  = rtype(7'h00, 5'd1, 5'd7, 3'b000, 5'd4);         // ADD.
        s_program[9]  = stype(12'd8, 5'd4, 5'd10);
        s_program[10] = rtype(7'h20, 5'd2, 5'd1, 3'b000, 5'd5);         // SUB.
        s_program[11] = stype(12'd12, 5'd5, 5'd10);
        s_program[12] = rtype(7'h00, 5'd8, 5'd7, 3'b111, 5'd6);         // AND.
        s_program[13] = stype(12'd16, 5'd6, 5'd10);
        s_program[14] = rtype(7'h00, 5'd8, 5'd1, 3'b110, 5'd6);         // OR.
        s_program[15] = stype(12'd20, 5'd6, 5'd10);
        s_program[16] = rtype(7'h00, 5'd2, 5'd7, 3'b100, 5'd6);         // XOR.
        s_program[17] = stype(12'd24, 5'd6, 5'd10);
        s_program[18] = rtype(7'h00, 5'd1, 5'd2, 3'b010, 5'd6);         // SLT.
        s_program[19] = stype(12'd28, 5'd6, 5'd10);
        s_program[20] = rtype(7'h00, 5'd1, 5'd2, 3'b011, 5'd6);         // SLTU.
        s_program[21] = stype(12'd32, 5'd6, 5'd10);
        s_program[22] = itype(12'd8, 5'd10, 3'b010, 5'd11, OPC_LOAD);   // LW back.
        s_program[23] = rtype(7'h00, 5'd5, 5'd11, 3'b000, 5'd12);
        s_program[24] = stype(12'd36, 5'd12, 5'd10);
        // Taken branches skip the poison stores.
        s_program[25] = btype(13'd8, 5'd1, 5'd1, 3'b000);
        s_program[26] = stype(12'd40, 5'd8, 5'd10);
        s_program[27] = btype(13'd8, 5'd2, 5'd1, 3'b001);
        s_program[28] = stype(12'd44, 5'd8, 5'd10);
        // Not taken.
        s_program[29] = btype(13'd8, 5'd2, 5'd1, 3'b000);
        s_program[30] = stype(12'd48, 5'd1, 5'd10);
        s_program[31] = btype(13'd8, 5'd1, 5'd1, 3'b001);
        s_program[32] = stype(12'd52, 5'd3, 5'd10);
        s_program[33] = jtype(21'd12, 5'd13);                            // Link is 0x88.
        s_program[34] = stype(12'd56, 5'd8, 5'd10);
        s_program[35] = stype(12'd60, 5'd8, 5'd10);
        s_program[36] = stype(12'd64, 5'd13, 5'd10);
        s_program[37] = jtype(21'd0, 5'd0);
    endtask

    task automatic list_expected_writes();
        exp_writes[0]  = '{addr: 32'h0000_0200, wdata: 32'h0000_0019};
        exp_writes[1]  = '{addr: 32'h0000_0204, wdata: 32'h1234_5000};
        exp_writes[2]  = '{addr: 32'h0000_0208, wdata: 32'h1234_5691};
        exp_writes[3]  = '{addr: 32'h0000_020C, wdata: 32'h0000_0020};
        exp_writes[4]  = '{addr: 32'h0000_0210, wdata: 32'h1234_5600};
        exp_writes[5]  = '{addr: 32'h0000_0214, wdata: 32'hFFFF_FF19};
        exp_writes[6]  = '{addr: 32'h0000_0218, wdata: 32'hEDCB_A981};
        exp_writes[7]  = '{addr: 32'h0000_021C, wdata: 32'h0000_0001};
        exp_writes[8]  = '{addr: 32'h0000_0220, wdata: 32'h0000_0000};
        exp_writes[9]  = '{addr: 32'h0000_0224, wdata: 32'h1234_56B1};
        exp_writes[10] = '{addr: 32'h0000_0230, wdata: 32'h0000_0019};
        exp_writes[11] = '{addr: 32'h0000_0234, wdata: 32'h1234_5000};
        exp_writes[12] = '{addr: 32'h0000_0240, wdata: 32'h0000_0088};
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "Run stopped at the first mismatch.");
        end
    endtask

    // ------------------------------
    // Clock, write capture, cycle limit.
    // ------------------------------
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (s_b_resp) begin
            seen_q.push_back(s_wr);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the program did not finish within %0d cycles.", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $fatal(1, "Run stopped by the cycle limit.");
        end
    end

    // ------------------------------
    // Main sequence.
    // ------------------------------
    initial begin
        i_rst_n = 1'b0;
        assemble_program();
        list_expected_writes();
        repeat (3) @(posedge clk);
        check_value("o_access in reset", 32'(s_access), 32'd0);
        check_value("o_start_read in reset", 32'(s_start_read), 32'd0);
        check_value("o_start_write in reset", 32'(s_start_write), 32'd0);
        #1;
        i_rst_n = 1'b1;

        // First fetch comes from the reset PC.
        do begin
            @(posedge clk);
        end while (!s_start_read);
        check_value("first fetch address", s_req.addr, `CORE_RESET_PC);

        for (int i = 0; i < N_WRITES; i++) begin
            while (seen_q.size() <= i) begin
                @(posedge clk);
            end
            check_value($sformatf("write %0d address", i), seen_q[i].addr, exp_writes[i].addr);
            check_value($sformatf("write %0d data", i), seen_q[i].wdata, exp_writes[i].wdata);
        end

        // Core now spins on the JAL loop and stores nothing more.
        repeat (IDLE_CYCLES) @(posedge clk);
        check_value("number of writes", 32'(seen_q.size()), 32'(N_WRITES));

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* all.f */
+incdir+hdl
hdl/core_pkg.sv
hdl/alu.sv
hdl/extend_imm.sv
hdl/register_file.sv
hdl/datapath_regs.sv
hdl/control_unit.sv
hdl/core_top.sv
verif/mem_model.sv
verif/tb_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_core \
    && ./obj_dir/Vtb_core | tee /dev/stderr | grep -qxF "=== PASS ===" \
    && echo "Simulation run passed." \
    || { echo "Simulation run failed."; exit 1; }
